// ==== files.f ====
source/z80_isa_pkg.sv
source/z80_flags_pkg.sv
source/alu_insn_decode.sv
source/z80_regfile.sv
source/alu_exec.sv
source/retire_queue.sv
source/z80_alu_core.sv
test/z80_alu_core_asserts.sv
test/tb_z80_alu_core.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_z80_alu_core \
    -f files.f --Mdir "$BUILD_DIR" -o sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/sim" +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== source/alu_exec.sv ====
/*
 * Executor: computes the ALU result and flags, writes A, F and IP back
 * and pushes the retire record, all on the same edge.
 */

`timescale 1ns/10ps

module alu_exec (
    input  logic                          dec_valid,
    output logic                          dec_ready,
    input  z80_isa_pkg::alu_func_e        dec_func,
    input  z80_isa_pkg::reg_sel_e         dec_src,
    input  logic                          dec_illegal,
    output z80_isa_pkg::reg_sel_e         src_sel,
    input  logic [7:0]                    src_data,
    input  logic [7:0]                    a_cur,
    input  z80_flags_pkg::flag_reg_u      f_cur,
    input  logic [z80_isa_pkg::IP_W-1:0]  ip_cur,
    output logic                          wb_en,
    output logic [7:0]                    wb_a,
    output z80_flags_pkg::flag_reg_u      wb_f,
    output logic                          push_valid,
    input  logic                          push_ready,
    output logic [7:0]                    push_a,
    output z80_flags_pkg::flag_reg_u      push_f,
    output logic [z80_isa_pkg::IP_W-1:0]  push_ip,
    output logic                          push_illegal
);

    logic                     is_sub;
    logic                     is_logic;
    logic                     carry_in;
    logic                     cin;
    logic [7:0]               operand;
    logic [8:0]               sum;
    logic [4:0]               low_sum;
    logic                     overflow;
    logic [7:0]               result;
    logic [7:0]               new_a;
    z80_flags_pkg::flag_reg_u new_f;

    assign src_sel = dec_src;

    assign is_sub   = (dec_func == z80_isa_pkg::ALU_SUB) || (dec_func == z80_isa_pkg::ALU_SBC) ||
                      (dec_func == z80_isa_pkg::ALU_CP);
    assign is_logic = (dec_func == z80_isa_pkg::ALU_AND) || (dec_func == z80_isa_pkg::ALU_XOR) ||
                      (dec_func == z80_isa_pkg::ALU_OR);

    assign carry_in = ((dec_func == z80_isa_pkg::ALU_ADC) || (dec_func == z80_isa_pkg::ALU_SBC)) &&
                      f_cur.bits.c;

    // subtraction runs as a + ~b + 1, a borrow-in drops the +1.
    assign operand = is_sub ? ~src_data : src_data;
    assign cin     = is_sub ^ carry_in;
    assign sum     = {1'b0, a_cur} + {1'b0, operand} + {8'h00, cin};
    assign low_sum = {1'b0, a_cur[3:0]} + {1'b0, operand[3:0]} + {4'h0, cin};

    assign overflow = (a_cur[7] == operand[7]) && (sum[7] != a_cur[7]);

    always_comb begin
        result = sum[7:0];
        case (dec_func)
            z80_isa_pkg::ALU_AND: result = a_cur & src_data;
            z80_isa_pkg::ALU_XOR: result = a_cur ^ src_data;
            z80_isa_pkg::ALU_OR:  result = a_cur | src_data;
            default:              result = sum[7:0];
        endcase
    end

    assign new_a = (dec_func == z80_isa_pkg::ALU_CP) ? a_cur : result; // CP only compares.

    // for subtract forms C and H report a borrow, so the carry out is inverted.
    always_comb begin
        new_f.raw                       = f_cur.raw;
        new_f.raw[z80_flags_pkg::FLAG_S] = result[7];
        new_f.raw[z80_flags_pkg::FLAG_Z] = (result == 8'h00);
        new_f.raw[z80_flags_pkg::FLAG_5] = f_cur.bits.f5;
        new_f.raw[z80_flags_pkg::FLAG_H] = (dec_func == z80_isa_pkg::ALU_AND) ||
                                           (!is_logic && (low_sum[4] ^ is_sub));
        new_f.raw[z80_flags_pkg::FLAG_3] = f_cur.bits.f3;
        new_f.raw[z80_flags_pkg::FLAG_PV] = is_logic ? ~^result : overflow;
        new_f.raw[z80_flags_pkg::FLAG_N] = is_sub;
        new_f.raw[z80_flags_pkg::FLAG_C] = !is_logic && (sum[8] ^ is_sub);
    end

    // the record and the write-back share one transfer edge.
    assign push_valid   = dec_valid;
    assign dec_ready    = push_ready;
    assign push_illegal = dec_illegal;

    assign push_a  = dec_illegal ? a_cur : new_a;
    assign push_f  = dec_illegal ? f_cur : new_f;
    assign push_ip = dec_illegal ? ip_cur : ip_cur + 1'b1;

    assign wb_en = dec_valid && push_ready && !dec_illegal; // illegal bytes change nothing.
    assign wb_a  = new_a;
    assign wb_f  = new_f;

endmodule

// ==== source/alu_insn_decode.sv ====
/*
 * Input stage: accepts instruction bytes, checks them against the ALU group
 * and holds one decoded instruction for the executor.
 */

`timescale 1ns/10ps

module alu_insn_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  insn_valid,
    output logic                  insn_ready,
    input  logic [7:0]            insn_byte,
    output logic                  dec_valid,
    input  logic                  dec_ready,
    output z80_isa_pkg::alu_func_e dec_func,
    output z80_isa_pkg::reg_sel_e  dec_src,
    output logic                  dec_illegal
);

    logic hold_valid;
    logic accept;
    logic byte_illegal;

    // a new byte may enter while the held one leaves.
    assign insn_ready = !hold_valid || dec_ready;
    assign accept     = insn_valid && insn_ready;

    assign byte_illegal = (insn_byte[7:6] != z80_isa_pkg::ALU_GROUP_PREFIX) ||
                          (insn_byte[2:0] == z80_isa_pkg::REG_MEM); // (HL) is not handled.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (insn_ready) begin
            hold_valid <= insn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_func    <= z80_isa_pkg::alu_func_e'(insn_byte[5:3]);
            dec_src     <= z80_isa_pkg::reg_sel_e'(insn_byte[2:0]);
            dec_illegal <= byte_illegal;
        end
    end

    assign dec_valid = hold_valid;

endmodule

// ==== source/retire_queue.sv ====
/*
 * Circular FIFO of retire records with a valid/ready drain port.
 */

`timescale 1ns/10ps

module retire_queue #(
    parameter int DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push_valid,
    output logic                          push_ready,
    input  logic [7:0]                    push_a,
    input  z80_flags_pkg::flag_reg_u      push_f,
    input  logic [z80_isa_pkg::IP_W-1:0]  push_ip,
    input  logic                          push_illegal,
    output logic                          retire_valid,
    input  logic                          retire_ready,
    output logic [7:0]                    retire_a,
    output z80_flags_pkg::flag_reg_u      retire_f,
    output logic [z80_isa_pkg::IP_W-1:0]  retire_ip,
    output logic                          retire_illegal
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [7:0]                   mem_a   [DEPTH];
    z80_flags_pkg::flag_reg_u     mem_f   [DEPTH];
    logic [z80_isa_pkg::IP_W-1:0] mem_ip  [DEPTH];
    logic                         mem_ill [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push_fire;
    logic             pop_fire;

    assign push_ready   = (count != (PTR_W + 1)'(DEPTH));
    assign retire_valid = (count != '0);
    assign push_fire    = push_valid && push_ready;
    assign pop_fire     = retire_valid && retire_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so it wraps.
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem_a[wr_ptr]   <= push_a;
            mem_f[wr_ptr]   <= push_f;
            mem_ip[wr_ptr]  <= push_ip;
            mem_ill[wr_ptr] <= push_illegal;
        end
    end

    assign retire_a       = mem_a[rd_ptr];
    assign retire_f       = mem_f[rd_ptr];
    assign retire_ip      = mem_ip[rd_ptr];
    assign retire_illegal = mem_ill[rd_ptr];

endmodule

// ==== source/z80_alu_core.sv ====
/*
 * Top level of the ALU subsystem: decoder, register file, executor
 * and retire queue.
 */

`timescale 1ns/10ps

module z80_alu_core #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          insn_valid,
    output logic                          insn_ready,
    input  logic [7:0]                    insn_byte,
    input  logic                          load_en,
    input  logic [3:0]                    load_sel,
    input  logic [7:0]                    load_data,
    output logic                          retire_valid,
    input  logic                          retire_ready,
    output logic [7:0]                    retire_a,
    output z80_flags_pkg::flag_reg_u      retire_f,
    output logic [z80_isa_pkg::IP_W-1:0]  retire_ip,
    output logic                          retire_illegal
);

    logic                         dec_valid;
    logic                         dec_ready;
    z80_isa_pkg::alu_func_e       dec_func;
    z80_isa_pkg::reg_sel_e        dec_src;
    logic                         dec_illegal;
    z80_isa_pkg::reg_sel_e        src_sel;
    logic [7:0]                   src_data;
    logic [7:0]                   a_cur;
    z80_flags_pkg::flag_reg_u     f_cur;
    logic [z80_isa_pkg::IP_W-1:0] ip_cur;
    logic                         wb_en;
    logic [7:0]                   wb_a;
    z80_flags_pkg::flag_reg_u     wb_f;
    logic                         push_valid;
    logic                         push_ready;
    logic [7:0]                   push_a;
    z80_flags_pkg::flag_reg_u     push_f;
    logic [z80_isa_pkg::IP_W-1:0] push_ip;
    logic                         push_illegal;

    alu_insn_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .insn_valid  (insn_valid),
        .insn_ready  (insn_ready),
        .insn_byte   (insn_byte),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_func    (dec_func),
        .dec_src     (dec_src),
        .dec_illegal (dec_illegal)
    );

    z80_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_sel   (src_sel),
        .src_data  (src_data),
        .a_cur     (a_cur),
        .f_cur     (f_cur),
        .ip_cur    (ip_cur),
        .wb_en     (wb_en),
        .wb_a      (wb_a),
        .wb_f      (wb_f),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_data (load_data)
    );

    alu_exec u_exec (
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_func     (dec_func),
        .dec_src      (dec_src),
        .dec_illegal  (dec_illegal),
        .src_sel      (src_sel),
        .src_data     (src_data),
        .a_cur        (a_cur),
        .f_cur        (f_cur),
        .ip_cur       (ip_cur),
        .wb_en        (wb_en),
        .wb_a         (wb_a),
        .wb_f         (wb_f),
        .push_valid   (push_valid),
        .push_ready   (push_ready),
        .push_a       (push_a),
        .push_f       (push_f),
        .push_ip      (push_ip),
        .push_illegal (push_illegal)
    );

    retire_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .push_valid     (push_valid),
        .push_ready     (push_ready),
        .push_a         (push_a),
        .push_f         (push_f),
        .push_ip        (push_ip),
        .push_illegal   (push_illegal),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_a       (retire_a),
        .retire_f       (retire_f),
        .retire_ip      (retire_ip),
        .retire_illegal (retire_illegal)
    );

endmodule

// ==== source/z80_flags_pkg.sv ====
/*
 * Flag bit positions and the F register view as raw byte or named flags.
 */

package z80_flags_pkg;

    localparam int FLAG_S  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_5  = 5;
    localparam int FLAG_H  = 4;
    localparam int FLAG_3  = 3;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N  = 1;
    localparam int FLAG_C  = 0;

    // field order follows the bit positions above, msb first.
    typedef struct packed {
        logic s;
        logic z;
        logic f5; // undocumented copy bit.
        logic h;
        logic f3; // undocumented copy bit.
        logic pv;
        logic n;
        logic c;
    } flag_bits_s;

    typedef union packed {
        logic [7:0] raw;
        flag_bits_s bits;
    } flag_reg_u;

endpackage

// ==== source/z80_isa_pkg.sv ====
/*
 * Instruction encoding for the eight-bit register ALU group:
 * ALU function codes, register codes, the group prefix and the IP width.
 */

package z80_isa_pkg;

    // bits 7:6 of every byte in the group.
    localparam logic [1:0] ALU_GROUP_PREFIX = 2'b10;

    localparam int IP_W = 16; // instruction pointer width.

    // bits 5:3 of the opcode select the operation.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7
    } alu_func_e;

    // bits 2:0 of the opcode select the second operand.
    // code 6 is the (HL) memory form, which has no register behind it.
    typedef enum logic [2:0] {
        REG_B   = 3'd0,
        REG_C   = 3'd1,
        REG_D   = 3'd2,
        REG_E   = 3'd3,
        REG_H   = 3'd4,
        REG_L   = 3'd5,
        REG_MEM = 3'd6,
        REG_A   = 3'd7
    } reg_sel_e;

endpackage

// ==== source/z80_regfile.sv ====
/*
 * Register file with A, F, B, C, D, E, H, L and the instruction pointer.
 * Asynchronous operand read, ALU write-back and an external load port.
 */

`timescale 1ns/10ps

module z80_regfile (
    input  logic                              clk,
    input  logic                              rst_n,
    input  z80_isa_pkg::reg_sel_e             src_sel,
    output logic [7:0]                        src_data,
    output logic [7:0]                        a_cur,
    output z80_flags_pkg::flag_reg_u          f_cur,
    output logic [z80_isa_pkg::IP_W-1:0]      ip_cur,
    input  logic                              wb_en,
    input  logic [7:0]                        wb_a,
    input  z80_flags_pkg::flag_reg_u          wb_f,
    input  logic                              load_en,
    input  logic [3:0]                        load_sel,
    input  logic [7:0]                        load_data
);

    logic [7:0]                   reg_a;
    logic [7:0]                   reg_b;
    logic [7:0]                   reg_c;
    logic [7:0]                   reg_d;
    logic [7:0]                   reg_e;
    logic [7:0]                   reg_h;
    logic [7:0]                   reg_l;
    z80_flags_pkg::flag_reg_u     reg_f;
    logic [z80_isa_pkg::IP_W-1:0] reg_ip;

    always_comb begin
        case (src_sel)
            z80_isa_pkg::REG_B: src_data = reg_b;
            z80_isa_pkg::REG_C: src_data = reg_c;
            z80_isa_pkg::REG_D: src_data = reg_d;
            z80_isa_pkg::REG_E: src_data = reg_e;
            z80_isa_pkg::REG_H: src_data = reg_h;
            z80_isa_pkg::REG_L: src_data = reg_l;
            z80_isa_pkg::REG_A: src_data = reg_a;
            default:            src_data = 8'h00; // memory form reads nothing.
        endcase
    end

    assign a_cur  = reg_a;
    assign f_cur  = reg_f;
    assign ip_cur = reg_ip;

    // load_sel codes 0 to 5 and 7 follow the register codes, 6 loads F,
    // 8 and 9 load the low and high byte of IP.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a     <= 8'h00;
            reg_b     <= 8'h00;
            reg_c     <= 8'h00;
            reg_d     <= 8'h00;
            reg_e     <= 8'h00;
            reg_h     <= 8'h00;
            reg_l     <= 8'h00;
            reg_f.raw <= 8'h00;
            reg_ip    <= '0;
        end else if (wb_en) begin
            reg_a  <= wb_a;
            reg_f  <= wb_f;
            reg_ip <= reg_ip + 1'b1; // every ALU instruction is one byte long.
        end else if (load_en) begin
            case (load_sel)
                4'd0:    reg_b       <= load_data;
                4'd1:    reg_c       <= load_data;
                4'd2:    reg_d       <= load_data;
                4'd3:    reg_e       <= load_data;
                4'd4:    reg_h       <= load_data;
                4'd5:    reg_l       <= load_data;
                4'd6:    reg_f.raw   <= load_data;
                4'd7:    reg_a       <= load_data;
                4'd8:    reg_ip[7:0] <= load_data;
                4'd9:    reg_ip[15:8] <= load_data;
                default: ;
            endcase
        end
    end

endmodule

// ==== test/tb_z80_alu_core.sv ====
/*
 * Testbench for z80_alu_core: register loads, directed and random streams,
 * a reference model built from the flag rules and a retire scoreboard.
 */

`timescale 1ns/10ps

module tb_z80_alu_core;

    localparam int QUEUE_DEPTH    = 4;
    localparam int N_RANDOM       = 300;
    localparam int STIM_CYCLES    = 8 * 4 * 7 * 8 + N_RANDOM * 3 + 150;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    logic        clk;
    logic        rst_n;
    logic        insn_valid;
    logic        insn_ready;
    logic [7:0]  insn_byte;
    logic        load_en;
    logic [3:0]  load_sel;
    logic [7:0]  load_data;
    logic        retire_valid;
    logic        retire_ready;
    logic [7:0]  retire_a;
    logic [7:0]  retire_f;
    logic [15:0] retire_ip;
    logic        retire_illegal;

    logic [7:0]  m_reg [8]; // model registers by load code, F sits at code 6.
    logic [15:0] m_ip;
    logic [32:0] exp_q [$]; // {illegal, ip, f, a}.
    logic [31:0] lcg_state;
    int          errors;
    int          cycle_count;

    logic [15:0] pairs [7] = '{16'h0F01, 16'h7F01, 16'h0001, 16'h8080,
                               16'hFFFF, 16'h55AA, 16'h3C3C};
    logic [7:0]  flag_vals [4] = '{8'h28, 8'h29, 8'h00, 8'h01};
    logic [7:0]  src_vals [8] = '{8'h01, 8'h80, 8'h7F, 8'hF0, 8'h0F, 8'h55, 8'h28, 8'h3C};
    logic [7:0]  bad_bytes [6] = '{8'h00, 8'h76, 8'hC6, 8'hFF, 8'h3E, 8'hBE};

    z80_alu_core #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // mostly group bytes, now and then any byte at all.
    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = next_rand();
        return (r[31:29] == 3'b000) ? r[7:0] : {2'b10, r[13:8]};
    endfunction

    function automatic int to_signed(input int v);
        return (v > 127) ? v - 256 : v;
    endfunction

    task automatic model_step(input logic [7:0] op);
        logic [2:0] fn;
        logic [7:0] old_f;
        logic [7:0] res;
        int         av, bv, ci, full, half, sv;
        logic       h, pv, n, c;
        fn    = op[5:3];
        old_f = m_reg[6];
        if (op[7:6] != 2'b10 || op[2:0] == 3'd6) begin
            exp_q.push_back({1'b1, m_ip, old_f, m_reg[7]});
            return;
        end
        av = m_reg[7];
        bv = m_reg[op[2:0]];
        ci = (fn == 3'd1 || fn == 3'd3) ? int'(old_f[0]) : 0;
        n  = (fn == 3'd2 || fn == 3'd3 || fn == 3'd7);
        if (fn <= 3'd1) begin
            full = av + bv + ci;
            half = (av % 16) + (bv % 16) + ci;
            sv   = to_signed(av) + to_signed(bv) + ci;
            c    = (full > 255);
            h    = (half > 15);
            pv   = (sv > 127) || (sv < -128);
        end else if (n) begin
            full = av - bv - ci;
            half = (av % 16) - (bv % 16) - ci;
            sv   = to_signed(av) - to_signed(bv) - ci;
            c    = (full < 0);
            h    = (half < 0);
            pv   = (sv > 127) || (sv < -128);
        end else begin
            full = (fn == 3'd4) ? (av & bv) : (fn == 3'd5) ? (av ^ bv) : (av | bv);
            c    = 1'b0;
            h    = (fn == 3'd4);
            pv   = ($countones(full[7:0]) % 2) == 0;
        end
        res      = full[7:0];
        m_reg[6] = {res[7], res == 8'h00, old_f[5], h, old_f[3], pv, n, c};
        m_reg[7] = (fn == 3'd7) ? m_reg[7] : res;
        m_ip     = m_ip + 16'd1;
        exp_q.push_back({1'b0, m_ip, m_reg[6], m_reg[7]});
    endtask

    task automatic compare_field(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_retire();
        logic [32:0] rec;
        if (exp_q.size() == 0) begin
            $display("A record retired at %0t ns with no instruction outstanding", $time);
            errors++;
            return;
        end
        rec = exp_q.pop_front();
        compare_field("retire_a", rec[7:0], retire_a);
        compare_field("retire_f", rec[15:8], retire_f);
        compare_field("retire_ip", rec[31:16], retire_ip);
        compare_field("retire_illegal", rec[32], retire_illegal);
    endtask

    // mid-cycle look at both handshakes, the transfer happens on the next edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (retire_valid && retire_ready) check_retire();
            if (insn_valid && insn_ready) model_step(insn_byte);
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic send_insn(input logic [7:0] op);
        insn_valid = 1'b1;
        insn_byte  = op;
        @(negedge clk);
        while (!insn_ready) @(negedge clk);
        @(posedge clk);
        #10;
        insn_valid = 1'b0;
    endtask

    task automatic drain();
        retire_ready = 1'b1;
        while (exp_q.size() != 0) idle_cycles(1);
    endtask

    task automatic load_reg(input logic [3:0] sel, input logic [7:0] data);
        load_en   = 1'b1;
        load_sel  = sel;
        load_data = data;
        if (sel == 4'd8) m_ip[7:0] = data;
        else if (sel == 4'd9) m_ip[15:8] = data;
        else m_reg[sel[2:0]] = data;
        idle_cycles(1);
        load_en = 1'b0;
    endtask

    task automatic run_case(input logic [7:0] a, input logic [7:0] b,
                            input logic [7:0] f, input logic [7:0] op);
        drain();
        load_reg(4'd7, a);
        load_reg(4'd0, b);
        load_reg(4'd6, f);
        send_insn(op);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        int          sent;
        int          assert_errors;
        logic [31:0] rnd;
        logic        took;
        rst_n        = 1'b1;
        insn_valid   = 1'b0;
        insn_byte    = 8'h00;
        load_en      = 1'b0;
        load_sel     = 4'd0;
        load_data    = 8'h00;
        retire_ready = 1'b1;
        lcg_state    = 32'h705c6bc1;
        errors       = 0;
        m_ip         = 16'h0000;
        foreach (m_reg[i]) m_reg[i] = 8'h00;
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #10 rst_n = 1'b1;

        send_insn(8'h80); // first result proves the registers came out of reset as zero.
        for (int fn = 0; fn < 8; fn++) begin
            for (int fi = 0; fi < 4; fi++) begin
                for (int pi = 0; pi < 7; pi++) begin
                    run_case(pairs[pi][15:8], pairs[pi][7:0], flag_vals[fi],
                             {2'b10, 3'(fn), 3'b000});
                end
            end
        end

        drain();
        for (int r = 0; r < 8; r++) load_reg(4'(r), src_vals[r]);
        for (int s = 0; s < 8; s++) begin
            send_insn({5'b10000, 3'(s)});
            send_insn({5'b10101, 3'(s)});
        end
        foreach (bad_bytes[i]) send_insn(bad_bytes[i]);

        drain();
        load_reg(4'd8, 8'hFE);
        load_reg(4'd9, 8'hFF);
        repeat (3) send_insn(8'h8F); // IP runs across 0xFFFF.
        send_insn(8'hBE);

        // queue and decoder fill up while nothing drains.
        drain();
        retire_ready = 1'b0;
        repeat (QUEUE_DEPTH + 1) send_insn(random_byte());
        idle_cycles(3);
        drain();

        for (int r = 0; r < 8; r++) load_reg(4'(r), 8'(next_rand() >> 8));
        sent = 0;
        while (sent < N_RANDOM) begin
            rnd          = next_rand();
            retire_ready = (rnd[3:2] != 2'b00);
            if (!insn_valid && rnd[6:4] != 3'b000) begin
                insn_valid = 1'b1;
                insn_byte  = random_byte();
            end
            @(negedge clk);
            took = insn_valid && insn_ready;
            @(posedge clk);
            #10;
            if (took) begin
                insn_valid = 1'b0;
                sent++;
            end
        end

        drain();
        idle_cycles(2);
        assert_errors = u_dut.u_asserts.fail_count;
        $display("Errors: %0d scoreboard, %0d assertion", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/z80_alu_core_asserts.sv ====
/*
 * Reset, handshake, latency and back-pressure assertions for z80_alu_core.
 */

`timescale 1ns/10ps

module z80_alu_core_asserts #(
    parameter int DEPTH = 4
) (
    input logic        clk,
    input logic        rst_n,
    input logic        insn_valid,
    input logic        insn_ready,
    input logic [7:0]  insn_byte,
    input logic        dec_valid,
    input logic        dec_ready,
    input logic [2:0]  dec_func,
    input logic [2:0]  dec_src,
    input logic        dec_illegal,
    input logic        push_valid,
    input logic        push_ready,
    input logic [7:0]  a_cur,
    input logic [7:0]  f_cur,
    input logic [15:0] ip_cur,
    input logic        retire_valid,
    input logic        retire_ready,
    input logic [7:0]  retire_a,
    input logic [7:0]  retire_f,
    input logic [15:0] retire_ip,
    input logic        retire_illegal
);

    int unsigned fail_count = 0;
    logic        idle_accept;
    int          queue_level; // records held in the retire queue.

    // a byte accepted while the decoder and the queue are both empty.
    assign idle_accept = insn_valid && insn_ready && !dec_valid && !retire_valid;

    // occupancy follows the transfers at the two ports of the queue.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            queue_level <= 0;
        end else begin
            queue_level <= queue_level + int'(push_valid && push_ready)
                                       - int'(retire_valid && retire_ready);
        end
    end

    reset_state: assert property (@(posedge clk)
        !rst_n |-> insn_ready && !dec_valid && !retire_valid &&
                   a_cur == 8'h00 && f_cur == 8'h00 && ip_cur == 16'h0000)
        else begin
            fail_count++;
            $error("outputs or registers are not in their reset state during reset");
        end

    insn_stable: assert property (@(posedge clk) disable iff (!rst_n)
        insn_valid && !insn_ready |=> insn_valid && $stable(insn_byte))
        else begin
            fail_count++;
            $error("instruction byte changed or was dropped before it was accepted");
        end

    dec_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable({dec_func, dec_src, dec_illegal}))
        else begin
            fail_count++;
            $error("decoded instruction changed while the executor was stalled");
        end

    retire_stable: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && !retire_ready |=>
            retire_valid && $stable({retire_a, retire_f, retire_ip, retire_illegal}))
        else begin
            fail_count++;
            $error("retire record changed before it was taken");
        end

    not_too_early: assert property (@(posedge clk) disable iff (!rst_n)
        idle_accept |=> dec_valid && !retire_valid)
        else begin
            fail_count++;
            $error("record did not reach the executor one cycle after acceptance");
        end

    two_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(idle_accept, 2) |-> retire_valid)
        else begin
            fail_count++;
            $error("record did not retire two cycles after acceptance");
        end

    ready_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (!insn_ready) == (dec_valid && queue_level >= DEPTH))
        else begin
            fail_count++;
            $error("insn_ready does not match the decoder and queue being full");
        end

endmodule

bind z80_alu_core z80_alu_core_asserts #(.DEPTH(QUEUE_DEPTH)) u_asserts (.*);
